//--- sifh_pkg.sv
package sifh_pkg;

    // time-bin code, 16 bins per pixel
    localparam int BIN_W = 4;
    localparam int BIN_NUM = 1 << BIN_W;

    // pixel index, up to 8 pixels
    localparam int PIX_W = 3;

    // one bin count, sized so a full frame cannot wrap it
    localparam int COUNT_W = 8;

    // flat address, pixel major and bin minor
    localparam int ADDR_W = PIX_W + BIN_W;

    // credit counters on both links
    localparam int CREDIT_W = 4;

    // readout FSM states
    typedef enum logic [1:0] {
        RO_IDLE    = 2'd0,
        RO_SWEEP   = 2'd1,
        RO_RELEASE = 2'd2
    } ro_state_t;

endpackage

//--- credit_event_fifo.sv
`timescale 1ns/1ns

module credit_event_fifo
    import sifh_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             ev_valid,
    input  logic [BIN_W-1:0] ev_bin,
    output logic             ev_credit,
    output logic             fifo_valid,
    output logic [BIN_W-1:0] fifo_bin,
    input  logic             fifo_pop
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [BIN_W-1:0] fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] occupancy;
    logic             pop_fire;

    // head is the oldest entry, valid while anything is stored
    assign fifo_valid = (occupancy != '0);
    assign fifo_bin   = fifo_mem[rd_ptr];
    assign pop_fire   = fifo_pop && fifo_valid;

    // one credit back to the source per popped entry
    assign ev_credit = pop_fire;

    // payload store
    always_ff @(posedge clk) begin
        if (ev_valid) begin
            fifo_mem[wr_ptr] <= ev_bin;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            // source only pushes while it holds a credit
            if (ev_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({ev_valid, pop_fire})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

//--- his_bank_mem.sv
`timescale 1ns/1ns

module his_bank_mem
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 4
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wr_bank,
    input  logic               wr_en,
    input  logic [ADDR_W-1:0]  wr_addr,
    input  logic [COUNT_W-1:0] wr_data,
    input  logic [ADDR_W-1:0]  rd_addr,
    output logic [COUNT_W-1:0] rd_count,
    input  logic               clr_en,
    input  logic               clr_bank,
    input  logic [ADDR_W:0]    sweep_addr,
    output logic [COUNT_W-1:0] sweep_count
);

    localparam int DEPTH = PIXEL_NUM * BIN_NUM;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // two banks of counts, one valid bit per entry per bank
    logic [COUNT_W-1:0] count_ram [2][DEPTH];
    logic [DEPTH-1:0]   valid_bits [2];

    logic               sweep_bank;
    logic [IDX_W-1:0]   sweep_idx;
    logic [IDX_W-1:0]   rd_idx;
    logic [IDX_W-1:0]   wr_idx;

    assign rd_idx     = rd_addr[IDX_W-1:0];
    assign wr_idx     = wr_addr[IDX_W-1:0];
    // bank select rides on the msb of the sweep address
    assign sweep_bank = sweep_addr[ADDR_W];
    assign sweep_idx  = sweep_addr[IDX_W-1:0];

    // builder reads its own bank, never-written bins read as zero
    assign rd_count    = valid_bits[wr_bank][rd_idx] ? count_ram[wr_bank][rd_idx] : '0;
    assign sweep_count = valid_bits[sweep_bank][sweep_idx] ?
                         count_ram[sweep_bank][sweep_idx] : '0;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            count_ram[wr_bank][wr_idx] <= wr_data;
        end
    end

    // first write marks the bin, flash clear drops a whole bank
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            valid_bits[0] <= '0;
            valid_bits[1] <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (clr_en && (clr_bank == b[0])) begin
                    valid_bits[b] <= '0;
                end else if (wr_en && (wr_bank == b[0])) begin
                    valid_bits[b][wr_idx] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- his_builder.sv
`timescale 1ns/1ns

module his_builder
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 4,
    parameter int DATA_NUM  = 3,
    parameter int ACQ_NUM   = 2
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               fifo_valid,
    input  logic [BIN_W-1:0]   fifo_bin,
    output logic               fifo_pop,
    output logic               wr_bank,
    output logic               wr_en,
    output logic [ADDR_W-1:0]  wr_addr,
    output logic [COUNT_W-1:0] wr_data,
    output logic [ADDR_W-1:0]  rd_addr,
    input  logic [COUNT_W-1:0] rd_count,
    output logic               clr_en,
    output logic               clr_bank,
    output logic               frame_done,
    input  logic               ro_busy
);

    localparam int IN_W  = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1;
    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    logic [IN_W-1:0]  input_cnt;
    logic [PIX_W-1:0] pixel_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic             bank;
    logic             pending;

    logic consume;
    logic last_in;
    logic last_pix;
    logic last_acq;
    logic frame_last;
    logic switch_now;

    // no pops while a finished frame waits for the readout
    assign consume  = fifo_valid && !pending;
    assign fifo_pop = consume;

    assign last_in  = (input_cnt == IN_W'(DATA_NUM - 1));
    assign last_pix = (pixel_cnt == PIX_W'(PIXEL_NUM - 1));
    assign last_acq = (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    // last event of the whole frame is being counted
    assign frame_last = consume && last_in && last_pix && last_acq;

    // swap only once the readout has let go of the other bank
    assign switch_now = (frame_last || pending) && !ro_busy;

    // pixel * BIN_NUM + bin is just the concatenation
    assign rd_addr = {pixel_cnt, fifo_bin};
    assign wr_addr = rd_addr;
    assign wr_data = rd_count + COUNT_W'(1);
    assign wr_en   = consume;
    assign wr_bank = bank;

    // the bank about to be filled loses its valid bits
    assign clr_en   = switch_now;
    assign clr_bank = ~bank;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            input_cnt  <= '0;
            pixel_cnt  <= '0;
            acq_cnt    <= '0;
            bank       <= 1'b0;
            pending    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= switch_now;

            if (switch_now) begin
                bank <= ~bank;
            end

            // remember a frame end that the readout blocked
            if (switch_now) begin
                pending <= 1'b0;
            end else if (frame_last) begin
                pending <= 1'b1;
            end

            // events per pixel, then pixels, then acquisitions
            if (consume) begin
                if (!last_in) begin
                    input_cnt <= input_cnt + 1'b1;
                end else begin
                    input_cnt <= '0;
                    if (!last_pix) begin
                        pixel_cnt <= pixel_cnt + 1'b1;
                    end else begin
                        pixel_cnt <= '0;
                        if (!last_acq) begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end else begin
                            acq_cnt <= '0;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- his_readout.sv
`timescale 1ns/1ns

module his_readout
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 4
) (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                frame_done,
    output logic                ro_busy,
    output logic [ADDR_W:0]     sweep_addr,
    input  logic [COUNT_W-1:0]  sweep_count,
    output logic                out_valid,
    output logic [PIX_W-1:0]    out_pixel,
    output logic [BIN_W-1:0]    out_bin,
    output logic [COUNT_W-1:0]  out_count,
    input  logic                out_credit,
    input  logic [CREDIT_W-1:0] out_credit_init
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(PIXEL_NUM * BIN_NUM - 1);

    ro_state_t           ro_state;
    logic [ADDR_W-1:0]   sweep_ptr;
    logic                build_bank;
    logic [CREDIT_W-1:0] credits;
    logic                credit_loaded;
    logic                send;

    // busy from the frame_done pulse through the release cycle
    assign ro_busy = frame_done || (ro_state != RO_IDLE);

    // finished bank is the one the builder just left
    assign sweep_addr = {~build_bank, sweep_ptr};

    // one word per cycle while a credit is held
    assign send      = (ro_state == RO_SWEEP) && (credits != '0);
    assign out_valid = send;
    assign out_pixel = sweep_ptr[ADDR_W-1:BIN_W];
    assign out_bin   = sweep_ptr[BIN_W-1:0];
    assign out_count = sweep_count;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            ro_state      <= RO_IDLE;
            sweep_ptr     <= '0;
            build_bank    <= 1'b0;
            credits       <= '0;
            credit_loaded <= 1'b0;
        end else begin
            // initial sink credits taken on the first cycle out of reset
            if (!credit_loaded) begin
                credits       <= out_credit_init;
                credit_loaded <= 1'b1;
            end else begin
                credits <= credits - CREDIT_W'(send) + CREDIT_W'(out_credit);
            end

            // follow the builder's bank swap
            if (frame_done) begin
                build_bank <= ~build_bank;
            end

            case (ro_state)
                RO_IDLE: begin
                    if (frame_done) begin
                        ro_state  <= RO_SWEEP;
                        sweep_ptr <= '0;
                    end
                end
                RO_SWEEP: begin
                    if (send) begin
                        if (sweep_ptr == LAST_ADDR) begin
                            ro_state  <= RO_RELEASE;
                            sweep_ptr <= '0;
                        end else begin
                            sweep_ptr <= sweep_ptr + 1'b1;
                        end
                    end
                end
                // one cycle of busy after the last word
                RO_RELEASE: begin
                    ro_state <= RO_IDLE;
                end
                default: begin
                    ro_state <= RO_IDLE;
                end
            endcase
        end
    end

endmodule

//--- sifh_top.sv
`timescale 1ns/1ns

module sifh_top
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM  = 4,
    parameter int DATA_NUM   = 3,
    parameter int ACQ_NUM    = 2,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                ev_valid,
    input  logic [BIN_W-1:0]    ev_bin,
    output logic                ev_credit,
    output logic                out_valid,
    output logic [PIX_W-1:0]    out_pixel,
    output logic [BIN_W-1:0]    out_bin,
    output logic [COUNT_W-1:0]  out_count,
    input  logic                out_credit,
    input  logic [CREDIT_W-1:0] out_credit_init,
    output logic                frame_done
);

    // fifo to builder
    logic               fifo_valid;
    logic [BIN_W-1:0]   fifo_bin;
    logic               fifo_pop;

    // builder to memory
    logic               wr_bank;
    logic               wr_en;
    logic [ADDR_W-1:0]  wr_addr;
    logic [COUNT_W-1:0] wr_data;
    logic [ADDR_W-1:0]  rd_addr;
    logic [COUNT_W-1:0] rd_count;
    logic               clr_en;
    logic               clr_bank;

    // readout side
    logic               ro_busy;
    logic [ADDR_W:0]    sweep_addr;
    logic [COUNT_W-1:0] sweep_count;

    credit_event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .combin_res (combin_res),
        .ev_valid   (ev_valid),
        .ev_bin     (ev_bin),
        .ev_credit  (ev_credit),
        .fifo_valid (fifo_valid),
        .fifo_bin   (fifo_bin),
        .fifo_pop   (fifo_pop)
    );

    his_builder #(
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) u_builder (
        .clk        (clk),
        .combin_res (combin_res),
        .fifo_valid (fifo_valid),
        .fifo_bin   (fifo_bin),
        .fifo_pop   (fifo_pop),
        .wr_bank    (wr_bank),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (rd_addr),
        .rd_count   (rd_count),
        .clr_en     (clr_en),
        .clr_bank   (clr_bank),
        .frame_done (frame_done),
        .ro_busy    (ro_busy)
    );

    his_bank_mem #(
        .PIXEL_NUM (PIXEL_NUM)
    ) u_mem (
        .clk         (clk),
        .combin_res  (combin_res),
        .wr_bank     (wr_bank),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_addr     (rd_addr),
        .rd_count    (rd_count),
        .clr_en      (clr_en),
        .clr_bank    (clr_bank),
        .sweep_addr  (sweep_addr),
        .sweep_count (sweep_count)
    );

    his_readout #(
        .PIXEL_NUM (PIXEL_NUM)
    ) u_readout (
        .clk             (clk),
        .combin_res      (combin_res),
        .frame_done      (frame_done),
        .ro_busy         (ro_busy),
        .sweep_addr      (sweep_addr),
        .sweep_count     (sweep_count),
        .out_valid       (out_valid),
        .out_pixel       (out_pixel),
        .out_bin         (out_bin),
        .out_count       (out_count),
        .out_credit      (out_credit),
        .out_credit_init (out_credit_init)
    );

endmodule

//--- sifh_properties.sv
`timescale 1ns/1ns

module sifh_properties
    import sifh_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input logic                         clk,
    input logic                         combin_res,
    input logic [$clog2(DEPTH+1)-1:0]   occupancy,
    input logic                         ev_valid,
    input logic [CREDIT_W-1:0]          credits,
    input logic                         out_valid,
    input logic                         out_credit,
    input logic                         frame_done,
    input logic                         ro_busy,
    input ro_state_t                    ro_state
);

    localparam int OCC_W = $clog2(DEPTH + 1);

    // a push into a full fifo means the source ignored its credits
    fifo_no_overflow: assert property (@(posedge clk) disable iff (!combin_res)
        ev_valid |-> (occupancy < OCC_W'(DEPTH)))
        else $error("event pushed into a full fifo of depth %0d", DEPTH);

    // empty counter and nothing returned, so the link stays quiet next cycle
    out_needs_credit: assert property (@(posedge clk) disable iff (!combin_res)
        (credits == '0) && !out_credit |=> !out_valid)
        else $error("out_valid high without a sink credit");

    // a bank swap only lands once the readout has let go
    swap_after_release: assert property (@(posedge clk) disable iff (!combin_res)
        frame_done |-> $past(!ro_busy))
        else $error("frame_done pulsed while the readout was still busy");

endmodule

// fifo side, readout inputs tied to their idle values
bind credit_event_fifo sifh_properties #(
    .DEPTH (FIFO_DEPTH)
) u_fifo_props (
    .clk        (clk),
    .combin_res (combin_res),
    .occupancy  (occupancy),
    .ev_valid   (ev_valid),
    .credits    ('0),
    .out_valid  (1'b0),
    .out_credit (1'b0),
    .frame_done (1'b0),
    .ro_busy    (1'b0),
    .ro_state   (sifh_pkg::RO_IDLE)
);

// readout side, fifo inputs tied low
bind his_readout sifh_properties u_ro_props (
    .clk        (clk),
    .combin_res (combin_res),
    .occupancy  ('0),
    .ev_valid   (1'b0),
    .credits    (credits),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .frame_done (frame_done),
    .ro_busy    (ro_busy),
    .ro_state   (ro_state)
);

//--- tb_sifh.sv
`timescale 1ns/1ns

module tb_sifh
    import sifh_pkg::*;
();

    localparam int PIXEL_NUM    = 4;
    localparam int DATA_NUM     = 3;
    localparam int ACQ_NUM      = 2;
    localparam int FIFO_DEPTH   = 8;
    localparam int EV_PER_FRAME = PIXEL_NUM * DATA_NUM * ACQ_NUM;
    localparam int WORDS        = PIXEL_NUM * BIN_NUM;

    localparam int KIND_RANDOM   = 0;
    localparam int KIND_SINGLE   = 1;
    localparam int KIND_DISJOINT = 2;

    // per row: frames, bin pattern, idle cycles after each source beat,
    // cycles per returned sink credit, sink credits at reset
    localparam int TEST_NUM = 5;
    string t_name [TEST_NUM] = '{"random_one_frame", "disjoint_flash_clear",
                                 "source_backpressure", "slow_sink", "stalled_back_to_back"};
    localparam int T_FRAMES [TEST_NUM] = '{1, 3, 3, 1, 3};
    localparam int T_KIND   [TEST_NUM] = '{KIND_RANDOM, KIND_DISJOINT, KIND_RANDOM,
                                           KIND_RANDOM, KIND_SINGLE};
    localparam int T_GAP    [TEST_NUM] = '{0, 1, 0, 2, 0};
    localparam int T_RATE   [TEST_NUM] = '{1, 1, 3, 5, 6};
    localparam int T_INIT   [TEST_NUM] = '{4, 8, 3, 1, 2};

    logic                clk = 1'b0;
    logic                combin_res;
    logic                ev_valid;
    logic [BIN_W-1:0]    ev_bin;
    logic                ev_credit;
    logic                out_valid;
    logic [PIX_W-1:0]    out_pixel;
    logic [BIN_W-1:0]    out_bin;
    logic [COUNT_W-1:0]  out_count;
    logic                out_credit;
    logic [CREDIT_W-1:0] out_credit_init;
    logic                frame_done;

    logic [31:0] rng_state = 32'd6700;
    // pending events, and expected words packed as pixel, bin, count
    int ev_q [$];
    int exp_q [$];
    int ev_idx;
    int src_credits;
    int gap_left;
    int src_gap;
    int rd_credits;
    int owed;
    int sink_tick;
    int sink_rate;
    int credit_pulses;
    int frames_seen;
    int words_got;
    int err_count = 0;
    int tests_failed = 0;

    sifh_top #(
        .PIXEL_NUM  (PIXEL_NUM),
        .DATA_NUM   (DATA_NUM),
        .ACQ_NUM    (ACQ_NUM),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .clk             (clk),
        .combin_res      (combin_res),
        .ev_valid        (ev_valid),
        .ev_bin          (ev_bin),
        .ev_credit       (ev_credit),
        .out_valid       (out_valid),
        .out_pixel       (out_pixel),
        .out_bin         (out_bin),
        .out_count       (out_count),
        .out_credit      (out_credit),
        .out_credit_init (out_credit_init),
        .frame_done      (frame_done)
    );

    always #4 clk = ~clk;

    function automatic int next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return int'(rng_state);
    endfunction

    // disjoint pattern: even frames low half, odd frames high half
    function automatic int pick_bin(int kind, int frame, int single_bin);
        int r;
        r = next_rand();
        case (kind)
            KIND_SINGLE:   return single_bin;
            KIND_DISJOINT: return (r & 7) + 8 * (frame % 2);
            default:       return r & 15;
        endcase
    endfunction

    function automatic int watchdog_cycles();
        int total;
        total = 0;
        for (int t = 0; t < TEST_NUM; t++) begin
            total += T_FRAMES[t] * EV_PER_FRAME;
        end
        return total * 40;
    endfunction

    task automatic check_value(string name, int got, int want);
        if (got !== want) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
            err_count++;
        end
    endtask

    task automatic report_failure(string what);
        $display("Error: %s", what);
        err_count++;
    endtask

    // reference histogram per frame, events ordered acq, pixel, event
    task automatic build_stimulus(int t);
        int hist [WORDS];
        int single_bin;
        int bin;
        ev_q.delete();
        exp_q.delete();
        for (int f = 0; f < T_FRAMES[t]; f++) begin
            for (int a = 0; a < WORDS; a++) begin
                hist[a] = 0;
            end
            single_bin = next_rand() & 15;
            for (int acq = 0; acq < ACQ_NUM; acq++) begin
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    for (int d = 0; d < DATA_NUM; d++) begin
                        bin = pick_bin(T_KIND[t], f, single_bin);
                        ev_q.push_back(bin);
                        hist[p * BIN_NUM + bin]++;
                    end
                end
            end
            // pixel major, bin minor
            for (int a = 0; a < WORDS; a++) begin
                exp_q.push_back(((a / BIN_NUM) << 12) | ((a % BIN_NUM) << 8) | hist[a]);
            end
        end
    endtask

    task automatic take_word();
        int w;
        if (rd_credits == 0) begin
            report_failure("out_valid high while the sink had no credit out");
        end else begin
            rd_credits--;
            owed++;
        end
        words_got++;
        if (exp_q.size() == 0) begin
            report_failure("output word arrived when none was expected");
        end else begin
            w = exp_q.pop_front();
            check_value("out_pixel", int'(out_pixel), w >> 12);
            check_value("out_bin", int'(out_bin), (w >> 8) & 15);
            check_value("out_count", int'(out_count), w & 255);
        end
    endtask

    task automatic drive_source();
        if (gap_left > 0) begin
            gap_left--;
            ev_valid = 1'b0;
        end else if (src_credits > 0 && ev_idx < ev_q.size()) begin
            ev_valid = 1'b1;
            ev_bin = BIN_W'(ev_q[ev_idx]);
            ev_idx++;
            src_credits--;
            gap_left = src_gap;
        end else begin
            ev_valid = 1'b0;
        end
    endtask

    // one credit back per word, every sink_rate cycles at most
    task automatic drive_sink();
        if (owed == 0) begin
            sink_tick = 0;
        end else begin
            sink_tick++;
        end
        if (owed > 0 && sink_tick >= sink_rate) begin
            out_credit = 1'b1;
            owed--;
            sink_tick = 0;
        end else begin
            out_credit = 1'b0;
        end
    endtask

    // sample mid cycle, drive just after the edge
    task automatic run_cycle();
        @(negedge clk);
        if (out_valid) begin
            take_word();
        end
        // credit driven this cycle counts from the next one
        if (out_credit) begin
            rd_credits++;
        end
        if (ev_credit) begin
            src_credits++;
            credit_pulses++;
            if (src_credits > FIFO_DEPTH) begin
                report_failure("ev_credit returned more credits than events were sent");
            end
        end
        if (frame_done) begin
            frames_seen++;
        end
        @(posedge clk);
        #1;
        drive_source();
        drive_sink();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        combin_res = 1'b0;
        ev_valid = 1'b0;
        out_credit = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        combin_res = 1'b1;
    endtask

    task automatic run_test(int t);
        int errs_before;
        errs_before = err_count;
        build_stimulus(t);
        ev_idx = 0;
        src_credits = FIFO_DEPTH;
        gap_left = 0;
        src_gap = T_GAP[t];
        rd_credits = T_INIT[t];
        owed = 0;
        sink_tick = 0;
        sink_rate = T_RATE[t];
        credit_pulses = 0;
        frames_seen = 0;
        words_got = 0;
        out_credit_init = CREDIT_W'(T_INIT[t]);
        apply_reset();
        while (ev_idx < ev_q.size() || exp_q.size() != 0) begin
            run_cycle();
        end
        // idle tail catches stray words or frame_done pulses
        repeat (8) run_cycle();
        check_value("frame_done pulses", frames_seen, T_FRAMES[t]);
        check_value("ev_credit pulses", credit_pulses, ev_q.size());
        check_value("words received", words_got, T_FRAMES[t] * WORDS);
        if (err_count == errs_before) begin
            $display("test %s: ok", t_name[t]);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", t_name[t], err_count - errs_before);
        end
    endtask

    initial begin
        combin_res = 1'b0;
        ev_valid = 1'b0;
        ev_bin = '0;
        out_credit = 1'b0;
        out_credit_init = '0;
        for (int t = 0; t < TEST_NUM; t++) begin
            run_test(t);
        end
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 TEST_NUM, TEST_NUM - tests_failed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // bound from the total event count of the table
    initial begin
        repeat (watchdog_cycles()) @(posedge clk);
        $display("Error: run did not finish within %0d cycles", watchdog_cycles());
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- build.f
sifh_pkg.sv
credit_event_fifo.sv
his_bank_mem.sv
his_builder.sv
his_readout.sv
sifh_top.sv
sifh_properties.sv
tb_sifh.sv

//--- Makefile
TOP := tb_sifh

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
